// ==== source/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Memory map seen by the core data bus, one 32-bit word per register
`define ADDR_MAP_BASE     32'hC000_0000

// Read dequeues a task and returns its timestamp
// Write stamps and enqueues the assembled child
`define ADDR_DEQ_TASK     (`ADDR_MAP_BASE + 32'h00)

// Current task fields on read, child fields on write
`define ADDR_TASK_HINT    (`ADDR_MAP_BASE + 32'h04)
`define ADDR_TASK_TTYPE   (`ADDR_MAP_BASE + 32'h08)
`define ADDR_TASK_ARG0    (`ADDR_MAP_BASE + 32'h0C)
`define ADDR_TASK_ARG1    (`ADDR_MAP_BASE + 32'h10)

// Read only
`define ADDR_CORE_ID      (`ADDR_MAP_BASE + 32'h14)

// Write only, data is ignored
`define ADDR_FINISH_TASK  (`ADDR_MAP_BASE + 32'h18)

// Bus word
`define DATA_W            32

// Task fields
`define TS_W              32
`define HINT_W            32
`define TTYPE_W           4
`define ARG_W             32
`define NUM_ARGS          2

// Commit queue bookkeeping
`define SLOT_W            6
`define CHILD_W           3

// Enqueue path sizing
`define ENQ_FIFO_DEPTH    4
`define ENQ_CREDITS       2

`endif

// ==== source/task_pkg.sv ====
`default_nettype none

`include "core_params.svh"

package task_pkg;

   // Task as exchanged with the commit queue
   typedef struct packed {
      logic [`TS_W-1:0]                ts;
      logic [`HINT_W-1:0]              hint;
      logic [`TTYPE_W-1:0]             ttype;
      logic [`NUM_ARGS*`ARG_W-1:0]     args;
   } task_t;

   // Slot of a running task inside the commit queue
   typedef logic [`SLOT_W-1:0] cq_slot_t;

   // Index of a child among the tasks enqueued by one parent
   typedef logic [`CHILD_W-1:0] child_id_t;

   // Enqueue request, the child plus where it came from
   typedef struct packed {
      task_t     task_data;
      cq_slot_t  slot;
      child_id_t child_id;
   } enq_req_t;

endpackage

`default_nettype wire

// ==== source/core_bus_pkg.sv ====
`default_nettype none

`include "core_params.svh"

package core_bus_pkg;

   // Data bus payload and address
   typedef logic [`DATA_W-1:0] data_word_t;
   typedef logic [31:0]        bus_addr_t;

   // Control states of the mmio unit
   typedef enum logic [2:0] {
      WAIT_CORE,
      NEXT_TASK,
      INFORM_CQ,
      IO_READ,
      FINISH_TASK
   } unit_state_t;

endpackage

`default_nettype wire

// ==== source/task_mmio_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module task_mmio_unit #(
   parameter int CORE_ID = 0
) (
   input  wire                           clk,
   input  wire                           rstn,

   input  wire                           cmd_valid,
   input  wire                           cmd_wr,
   input  wire core_bus_pkg::bus_addr_t  cmd_addr,
   input  wire core_bus_pkg::data_word_t cmd_data,
   output logic                          cmd_ready,
   output logic                          rsp_valid,
   output core_bus_pkg::data_word_t      rsp_data,

   output logic                          task_arvalid,
   input  wire                           task_rvalid,
   input  wire task_pkg::task_t          task_rdata,
   input  wire task_pkg::cq_slot_t       task_rslot,

   output logic                          start_task_valid,
   input  wire                           start_task_ready,
   output task_pkg::cq_slot_t            start_task_slot,

   output logic                          finish_task_valid,
   input  wire                           finish_task_ready,
   output task_pkg::cq_slot_t            finish_task_slot,
   output task_pkg::child_id_t           finish_task_num_children,

   output logic                          push_valid,
   output task_pkg::enq_req_t            push_req,
   input  wire                           push_credit
);

   localparam int CRED_W = $clog2(`ENQ_FIFO_DEPTH + 1);

   core_bus_pkg::unit_state_t state;
   core_bus_pkg::unit_state_t state_next;

   task_pkg::task_t          cur_task;
   task_pkg::cq_slot_t       cur_slot;
   core_bus_pkg::bus_addr_t  io_read_addr;

   logic [`HINT_W-1:0]       child_hint;
   logic [`TTYPE_W-1:0]      child_ttype;
   logic [`ARG_W-1:0]        child_arg0;
   logic [`ARG_W-1:0]        child_arg1;
   task_pkg::child_id_t      child_id;

   logic [CRED_W-1:0]        credits;
   logic                     credit_avail;
   logic                     ts_accept;

   // A push already in flight has not been charged yet
   assign credit_avail = credits > CRED_W'(push_valid);

   always_comb begin
      cmd_ready  = 1'b0;
      ts_accept  = 1'b0;
      state_next = state;
      case (state)
         core_bus_pkg::WAIT_CORE: begin
            if (cmd_valid && !cmd_wr) begin
               cmd_ready = 1'b1;
               if (cmd_addr == `ADDR_DEQ_TASK) begin
                  state_next = core_bus_pkg::NEXT_TASK;
               end else begin
                  state_next = core_bus_pkg::IO_READ;
               end
            end else if (cmd_valid && cmd_wr) begin
               case (cmd_addr)
                  `ADDR_DEQ_TASK: begin
                     cmd_ready = credit_avail;
                     ts_accept = credit_avail;
                  end
                  // Held on the bus until the commit queue takes it
                  `ADDR_FINISH_TASK: state_next = core_bus_pkg::FINISH_TASK;
                  default: cmd_ready = 1'b1;
               endcase
            end
         end
         core_bus_pkg::NEXT_TASK: begin
            if (task_rvalid) begin
               state_next = core_bus_pkg::INFORM_CQ;
            end
         end
         core_bus_pkg::INFORM_CQ: begin
            if (start_task_ready) begin
               state_next = core_bus_pkg::IO_READ;
            end
         end
         core_bus_pkg::IO_READ: begin
            state_next = core_bus_pkg::WAIT_CORE;
         end
         core_bus_pkg::FINISH_TASK: begin
            if (finish_task_ready) begin
               cmd_ready  = 1'b1;
               state_next = core_bus_pkg::WAIT_CORE;
            end
         end
         default: state_next = core_bus_pkg::WAIT_CORE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state      <= core_bus_pkg::WAIT_CORE;
         push_valid <= 1'b0;
         credits    <= CRED_W'(`ENQ_FIFO_DEPTH);
         child_id   <= '0;
      end else begin
         state      <= state_next;
         push_valid <= ts_accept;
         credits    <= credits - CRED_W'(push_valid) + CRED_W'(push_credit);
         if (task_arvalid && task_rvalid) begin
            child_id <= '0;
         end else if (ts_accept) begin
            child_id <= child_id + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (task_arvalid && task_rvalid) begin
         cur_task <= task_rdata;
         cur_slot <= task_rslot;
      end
      if (cmd_valid && cmd_ready && !cmd_wr) begin
         io_read_addr <= cmd_addr;
      end
   end

   // Child fields collect until the timestamp write
   always_ff @(posedge clk) begin
      if (cmd_valid && cmd_ready && cmd_wr) begin
         case (cmd_addr)
            `ADDR_TASK_HINT:  child_hint  <= cmd_data;
            `ADDR_TASK_TTYPE: child_ttype <= cmd_data[`TTYPE_W-1:0];
            `ADDR_TASK_ARG0:  child_arg0  <= cmd_data;
            `ADDR_TASK_ARG1:  child_arg1  <= cmd_data;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ts_accept) begin
         push_req.task_data.ts    <= cmd_data;
         push_req.task_data.hint  <= child_hint;
         push_req.task_data.ttype <= child_ttype;
         push_req.task_data.args  <= {child_arg1, child_arg0};
         push_req.slot            <= cur_slot;
         push_req.child_id        <= child_id;
      end
   end

   always_comb begin
      case (io_read_addr)
         `ADDR_DEQ_TASK:   rsp_data = cur_task.ts;
         `ADDR_TASK_HINT:  rsp_data = cur_task.hint;
         `ADDR_TASK_TTYPE: rsp_data = core_bus_pkg::data_word_t'(cur_task.ttype);
         `ADDR_TASK_ARG0:  rsp_data = cur_task.args[`ARG_W-1:0];
         `ADDR_TASK_ARG1:  rsp_data = cur_task.args[2*`ARG_W-1:`ARG_W];
         `ADDR_CORE_ID:    rsp_data = core_bus_pkg::data_word_t'(CORE_ID);
         default:          rsp_data = '0;
      endcase
   end

   assign rsp_valid                = (state == core_bus_pkg::IO_READ);
   assign task_arvalid             = (state == core_bus_pkg::NEXT_TASK);
   assign start_task_valid         = (state == core_bus_pkg::INFORM_CQ);
   assign finish_task_valid        = (state == core_bus_pkg::FINISH_TASK);
   assign start_task_slot          = cur_slot;
   assign finish_task_slot         = cur_slot;
   assign finish_task_num_children = child_id;

   // The credit is taken at the push, a cycle after the bus let the write in
   a_push_has_credit: assert property (@(posedge clk) disable iff (!rstn)
      push_valid |-> credits != '0);

   // FIFO never hands back more than it holds
   a_credit_bound: assert property (@(posedge clk) disable iff (!rstn)
      credits <= CRED_W'(`ENQ_FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== source/enq_task_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module enq_task_fifo (
   input  wire                      clk,
   input  wire                      rstn,

   input  wire                      push_valid,
   input  wire task_pkg::enq_req_t  push_req,
   output logic                     push_credit,

   output logic                     pop_valid,
   output task_pkg::enq_req_t       pop_req,
   input  wire                      pop_credit
);

   localparam int PTR_W = $clog2(`ENQ_FIFO_DEPTH);

   task_pkg::enq_req_t mem [`ENQ_FIFO_DEPTH];

   // Extra top bit tells full from empty
   logic [PTR_W:0] wr_ptr;
   logic [PTR_W:0] rd_ptr;
   logic [PTR_W:0] used;
   logic           empty;
   logic           full;

   // Single credit for the port's holding register
   logic           dn_credit;

   assign used  = wr_ptr - rd_ptr;
   assign empty = (used == '0);
   assign full  = (used == (PTR_W + 1)'(`ENQ_FIFO_DEPTH));

   assign pop_valid   = !empty && dn_credit;
   assign pop_req     = mem[rd_ptr[PTR_W-1:0]];
   assign push_credit = pop_valid;

   always_ff @(posedge clk) begin
      if (push_valid) begin
         mem[wr_ptr[PTR_W-1:0]] <= push_req;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         dn_credit <= 1'b1;
      end else begin
         if (push_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_valid) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         dn_credit <= (dn_credit && !pop_valid) || pop_credit;
      end
   end

   // Producer credits must keep it from overrunning the buffer
   a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
      push_valid |-> !full);

   // Port hands back a credit only for an entry it was given
   a_credit_return: assert property (@(posedge clk) disable iff (!rstn)
      pop_credit |-> !dn_credit || pop_valid);

endmodule

`default_nettype wire

// ==== source/enq_task_port.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module enq_task_port (
   input  wire                      clk,
   input  wire                      rstn,

   input  wire                      pop_valid,
   input  wire task_pkg::enq_req_t  pop_req,
   output logic                     pop_credit,

   output logic                     task_wvalid,
   output task_pkg::task_t          task_wdata,
   output task_pkg::cq_slot_t       task_cq_slot,
   output task_pkg::child_id_t      task_child_id,
   input  wire                      task_credit
);

   localparam int CRED_W = $clog2(`ENQ_CREDITS + 1);

   logic                hold_valid;
   task_pkg::enq_req_t  hold_req;
   logic                cand_valid;
   task_pkg::enq_req_t  cand_req;
   logic                issue;
   logic [CRED_W-1:0]   credits;

   // A fresh pop goes straight out when a queue credit is on hand
   assign cand_valid = hold_valid || pop_valid;
   assign cand_req   = hold_valid ? hold_req : pop_req;
   assign issue      = cand_valid && (credits != '0);
   assign pop_credit = issue;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         hold_valid  <= 1'b0;
         task_wvalid <= 1'b0;
         credits     <= CRED_W'(`ENQ_CREDITS);
      end else begin
         task_wvalid <= issue;
         credits     <= credits - CRED_W'(issue) + CRED_W'(task_credit);
         if (issue) begin
            hold_valid <= 1'b0;
         end else if (pop_valid) begin
            hold_valid <= 1'b1;
         end
      end
   end

   // Parked until the commit queue returns a credit
   always_ff @(posedge clk) begin
      if (pop_valid && !issue) begin
         hold_req <= pop_req;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         task_wdata    <= cand_req.task_data;
         task_cq_slot  <= cand_req.slot;
         task_child_id <= cand_req.child_id;
      end
   end

   // Commit queue returns no more credits than it granted
   a_credit_bound: assert property (@(posedge clk) disable iff (!rstn)
      credits <= CRED_W'(`ENQ_CREDITS));

endmodule

`default_nettype wire

// ==== source/task_core_shell.sv ====
`timescale 1ns/100ps
`default_nettype none

module task_core_shell #(
   parameter int CORE_ID = 0
) (
   input  wire                           clk,
   input  wire                           rstn,

   // Core data bus
   input  wire                           cmd_valid,
   input  wire                           cmd_wr,
   input  wire core_bus_pkg::bus_addr_t  cmd_addr,
   input  wire core_bus_pkg::data_word_t cmd_data,
   output logic                          cmd_ready,
   output logic                          rsp_valid,
   output core_bus_pkg::data_word_t      rsp_data,

   // Dequeue
   output logic                          task_arvalid,
   input  wire                           task_rvalid,
   input  wire task_pkg::task_t          task_rdata,
   input  wire task_pkg::cq_slot_t       task_rslot,

   // Start and finish
   output logic                          start_task_valid,
   input  wire                           start_task_ready,
   output task_pkg::cq_slot_t            start_task_slot,
   output logic                          finish_task_valid,
   input  wire                           finish_task_ready,
   output task_pkg::cq_slot_t            finish_task_slot,
   output task_pkg::child_id_t           finish_task_num_children,

   // Enqueue
   output logic                          task_wvalid,
   output task_pkg::task_t               task_wdata,
   output task_pkg::cq_slot_t            task_cq_slot,
   output task_pkg::child_id_t           task_child_id,
   input  wire                           task_credit
);

   logic                push_valid;
   task_pkg::enq_req_t  push_req;
   logic                push_credit;
   logic                pop_valid;
   task_pkg::enq_req_t  pop_req;
   logic                pop_credit;

   task_mmio_unit #(
      .CORE_ID(CORE_ID)
   ) u_mmio (
      .clk                      (clk),
      .rstn                     (rstn),
      .cmd_valid                (cmd_valid),
      .cmd_wr                   (cmd_wr),
      .cmd_addr                 (cmd_addr),
      .cmd_data                 (cmd_data),
      .cmd_ready                (cmd_ready),
      .rsp_valid                (rsp_valid),
      .rsp_data                 (rsp_data),
      .task_arvalid             (task_arvalid),
      .task_rvalid              (task_rvalid),
      .task_rdata               (task_rdata),
      .task_rslot               (task_rslot),
      .start_task_valid         (start_task_valid),
      .start_task_ready         (start_task_ready),
      .start_task_slot          (start_task_slot),
      .finish_task_valid        (finish_task_valid),
      .finish_task_ready        (finish_task_ready),
      .finish_task_slot         (finish_task_slot),
      .finish_task_num_children (finish_task_num_children),
      .push_valid               (push_valid),
      .push_req                 (push_req),
      .push_credit              (push_credit)
   );

   enq_task_fifo u_fifo (
      .clk         (clk),
      .rstn        (rstn),
      .push_valid  (push_valid),
      .push_req    (push_req),
      .push_credit (push_credit),
      .pop_valid   (pop_valid),
      .pop_req     (pop_req),
      .pop_credit  (pop_credit)
   );

   enq_task_port u_port (
      .clk           (clk),
      .rstn          (rstn),
      .pop_valid     (pop_valid),
      .pop_req       (pop_req),
      .pop_credit    (pop_credit),
      .task_wvalid   (task_wvalid),
      .task_wdata    (task_wdata),
      .task_cq_slot  (task_cq_slot),
      .task_child_id (task_child_id),
      .task_credit   (task_credit)
   );

endmodule

`default_nettype wire

// ==== verification/task_core_shell_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module task_core_shell_tb;

   localparam int CORE_ID  = 11;
   localparam int MAX_OPS  = 64;
   localparam int MAX_ARGS = 6;

   logic                      clk;
   logic                      rstn;
   logic                      cmd_valid;
   logic                      cmd_wr;
   core_bus_pkg::bus_addr_t   cmd_addr;
   core_bus_pkg::data_word_t  cmd_data;
   logic                      cmd_ready;
   logic                      rsp_valid;
   core_bus_pkg::data_word_t  rsp_data;
   logic                      task_arvalid;
   logic                      task_rvalid;
   task_pkg::task_t           task_rdata;
   task_pkg::cq_slot_t        task_rslot;
   logic                      start_task_valid;
   logic                      start_task_ready;
   task_pkg::cq_slot_t        start_task_slot;
   logic                      finish_task_valid;
   logic                      finish_task_ready;
   task_pkg::cq_slot_t        finish_task_slot;
   task_pkg::child_id_t       finish_task_num_children;
   logic                      task_wvalid;
   task_pkg::task_t           task_wdata;
   task_pkg::cq_slot_t        task_cq_slot;
   task_pkg::child_id_t       task_child_id;
   logic                      task_credit;

   // Stimulus lines as op code plus operands
   logic [95:0]               ops [MAX_OPS];
   logic [31:0]               opnd [MAX_OPS][MAX_ARGS];
   int                        n_ops = 0;
   bit                        loaded = 1'b0;

   int                        err_val = 0;
   int                        err_other = 0;
   int                        seed = 75721;
   int                        cycles = 0;

   // Commit queue model state
   task_pkg::task_t           deq_task = '0;
   task_pkg::cq_slot_t        deq_slot = '0;
   task_pkg::cq_slot_t        cur_slot = '0;
   task_pkg::cq_slot_t        exp_fin_slot = '0;
   task_pkg::child_id_t       exp_fin_num = '0;
   task_pkg::task_t           child_fields = '0;
   task_pkg::enq_req_t        exp_q [$];
   int                        owed = 0;
   bit                        credit_hold = 1'b0;

   task_core_shell #(
      .CORE_ID(CORE_ID)
   ) u_dut (
      .clk                      (clk),
      .rstn                     (rstn),
      .cmd_valid                (cmd_valid),
      .cmd_wr                   (cmd_wr),
      .cmd_addr                 (cmd_addr),
      .cmd_data                 (cmd_data),
      .cmd_ready                (cmd_ready),
      .rsp_valid                (rsp_valid),
      .rsp_data                 (rsp_data),
      .task_arvalid             (task_arvalid),
      .task_rvalid              (task_rvalid),
      .task_rdata               (task_rdata),
      .task_rslot               (task_rslot),
      .start_task_valid         (start_task_valid),
      .start_task_ready         (start_task_ready),
      .start_task_slot          (start_task_slot),
      .finish_task_valid        (finish_task_valid),
      .finish_task_ready        (finish_task_ready),
      .finish_task_slot         (finish_task_slot),
      .finish_task_num_children (finish_task_num_children),
      .task_wvalid              (task_wvalid),
      .task_wdata               (task_wdata),
      .task_cq_slot             (task_cq_slot),
      .task_child_id            (task_child_id),
      .task_credit              (task_credit)
   );

   task automatic check_word(input string name, input core_bus_pkg::data_word_t got,
                             input core_bus_pkg::data_word_t want);
      if (got !== want) begin
         $display("ERR %s got %h exp %h", name, got, want);
         err_val++;
      end
   endtask

   task automatic check_task(input string name, input task_pkg::task_t got,
                             input task_pkg::task_t want);
      if (got !== want) begin
         $display("ERR %s got %h exp %h", name, got, want);
         err_val++;
      end
   endtask

   task automatic check_slot(input string name, input task_pkg::cq_slot_t got,
                             input task_pkg::cq_slot_t want);
      if (got !== want) begin
         $display("ERR %s got %h exp %h", name, got, want);
         err_val++;
      end
   endtask

   task automatic check_child(input string name, input task_pkg::child_id_t got,
                              input task_pkg::child_id_t want);
      if (got !== want) begin
         $display("ERR %s got %h exp %h", name, got, want);
         err_val++;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("%s", msg);
      err_other++;
   endtask

   task automatic end_run();
      $display("Checks done with %0d value errors and %0d other errors", err_val, err_other);
      if (err_val == 0 && err_other == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   endtask

   function automatic int arg_count(input logic [95:0] op);
      case (op)
         "dequeue": return 6;
         "credit":  return 1;
         default:   return 2;
      endcase
   endfunction

   task automatic load_stimulus(output bit ok);
      int          fd;
      int          c;
      int          code;
      logic [95:0] op;
      logic [31:0] v;
      ok = 1'b0;
      fd = $fopen("verification/task_core_stimulus.txt", "r");
      if (fd == 0) begin
         return;
      end
      ok = 1'b1;
      while (!$feof(fd) && n_ops < MAX_OPS) begin
         op   = '0;
         code = $fscanf(fd, "%s", op);
         if (code == 1 && op == "#") begin
            c = $fgetc(fd);
            while (c != 10 && c != -1) begin
               c = $fgetc(fd);
            end
         end else if (code == 1) begin
            ops[n_ops] = op;
            for (int i = 0; i < arg_count(op); i++) begin
               code = $fscanf(fd, "%h", v);
               opnd[n_ops][i] = v;
            end
            n_ops++;
         end
      end
      $fclose(fd);
   endtask

   // Holds the command until the handshake and then drops it
   task automatic bus_cmd(input logic wr, input core_bus_pkg::bus_addr_t addr,
                          input core_bus_pkg::data_word_t data);
      @(posedge clk);
      cmd_valid <= 1'b1;
      cmd_wr    <= wr;
      cmd_addr  <= addr;
      cmd_data  <= data;
      @(negedge clk);
      while (!cmd_ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      cmd_valid <= 1'b0;
   endtask

   task automatic bus_read(input core_bus_pkg::bus_addr_t addr,
                           output core_bus_pkg::data_word_t data);
      bus_cmd(1'b0, addr, '0);
      @(negedge clk);
      while (!rsp_valid) begin
         @(negedge clk);
      end
      data = rsp_data;
   endtask

   task automatic run_op(input int k);
      core_bus_pkg::data_word_t rd;
      task_pkg::enq_req_t       req;
      case (ops[k])
         "dequeue": begin
            deq_task.ts    = opnd[k][0];
            deq_task.hint  = opnd[k][1];
            deq_task.ttype = opnd[k][2][`TTYPE_W-1:0];
            deq_task.args  = {opnd[k][4], opnd[k][3]};
            deq_slot       = opnd[k][5][`SLOT_W-1:0];
            cur_slot       = deq_slot;
            bus_read(`ADDR_DEQ_TASK, rd);
            check_word("rsp_data", rd, deq_task.ts);
         end
         "read": begin
            bus_read(opnd[k][0], rd);
            check_word("rsp_data", rd, opnd[k][1]);
         end
         "write": begin
            case (opnd[k][0])
               `ADDR_TASK_HINT:  child_fields.hint = opnd[k][1];
               `ADDR_TASK_TTYPE: child_fields.ttype = opnd[k][1][`TTYPE_W-1:0];
               `ADDR_TASK_ARG0:  child_fields.args[`ARG_W-1:0] = opnd[k][1];
               `ADDR_TASK_ARG1:  child_fields.args[2*`ARG_W-1:`ARG_W] = opnd[k][1];
               default: ;
            endcase
            bus_cmd(1'b1, opnd[k][0], opnd[k][1]);
         end
         "enqueue": begin
            req.task_data    = child_fields;
            req.task_data.ts = opnd[k][0];
            req.slot         = cur_slot;
            req.child_id     = opnd[k][1][`CHILD_W-1:0];
            exp_q.push_back(req);
            bus_cmd(1'b1, `ADDR_DEQ_TASK, opnd[k][0]);
         end
         "finish": begin
            exp_fin_slot = opnd[k][0][`SLOT_W-1:0];
            exp_fin_num  = opnd[k][1][`CHILD_W-1:0];
            bus_cmd(1'b1, `ADDR_FINISH_TASK, '0);
         end
         "credit": begin
            @(negedge clk);
            if (opnd[k][0] == 0) begin
               credit_hold = 1'b1;
            end else begin
               // Port must run dry of queue credits before they come back
               while (owed != `ENQ_CREDITS) begin
                  @(negedge clk);
               end
               credit_hold = 1'b0;
               while (exp_q.size() != 0) begin
                  @(negedge clk);
               end
            end
         end
         default: note_failure("unknown operation in the stimulus file");
      endcase
   endtask

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      wait (loaded);
      while (cycles < 200 * (n_ops + 1)) begin
         @(posedge clk);
         cycles++;
      end
      note_failure("timeout, the stimulus did not complete within the cycle limit");
      end_run();
   end

   initial begin : deq_model
      int d;
      forever begin
         @(negedge clk);
         if (rstn && task_arvalid) begin
            d = $random(seed) & 3;
            repeat (d + 1) @(posedge clk);
            task_rvalid <= 1'b1;
            task_rdata  <= deq_task;
            task_rslot  <= deq_slot;
            @(posedge clk);
            task_rvalid <= 1'b0;
         end
      end
   end

   initial begin : start_model
      int d;
      forever begin
         @(negedge clk);
         if (rstn && start_task_valid) begin
            check_slot("start_task_slot", start_task_slot, deq_slot);
            d = $random(seed) & 3;
            repeat (d + 1) @(posedge clk);
            start_task_ready <= 1'b1;
            @(posedge clk);
            start_task_ready <= 1'b0;
         end
      end
   end

   initial begin : finish_model
      int d;
      forever begin
         @(negedge clk);
         if (rstn && finish_task_valid) begin
            check_slot("finish_task_slot", finish_task_slot, exp_fin_slot);
            check_child("finish_task_num_children", finish_task_num_children, exp_fin_num);
            d = $random(seed) & 3;
            repeat (d + 1) @(posedge clk);
            finish_task_ready <= 1'b1;
            @(posedge clk);
            finish_task_ready <= 1'b0;
         end
      end
   end

   initial begin : enq_monitor
      task_pkg::enq_req_t want;
      forever begin
         @(negedge clk);
         if (rstn && task_wvalid) begin
            if (exp_q.size() == 0) begin
               note_failure("task issued to the commit queue with no enqueue pending");
            end else begin
               want = exp_q.pop_front();
               check_task("task_wdata", task_wdata, want.task_data);
               check_slot("task_cq_slot", task_cq_slot, want.slot);
               check_child("task_child_id", task_child_id, want.child_id);
            end
            owed++;
            if (owed > `ENQ_CREDITS) begin
               note_failure("more tasks in flight than commit-queue credits");
            end
         end
      end
   end

   // Returns one credit at a time after a random gap
   initial begin : credit_model
      forever begin
         @(posedge clk);
         if (rstn && !credit_hold && owed > 0 && ($random(seed) & 1) == 0) begin
            task_credit <= 1'b1;
            owed--;
         end else begin
            task_credit <= 1'b0;
         end
      end
   end

   initial begin
      bit ok;
      rstn              = 1'b0;
      cmd_valid         = 1'b0;
      cmd_wr            = 1'b0;
      cmd_addr          = '0;
      cmd_data          = '0;
      task_rvalid       = 1'b0;
      task_rdata        = '0;
      task_rslot        = '0;
      start_task_ready  = 1'b0;
      finish_task_ready = 1'b0;
      task_credit       = 1'b0;
      load_stimulus(ok);
      loaded = 1'b1;
      repeat (10) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      if (task_arvalid || start_task_valid || finish_task_valid || rsp_valid ||
          cmd_ready || task_wvalid) begin
         note_failure("a control output is high right after reset");
      end
      if (u_dut.u_mmio.state != core_bus_pkg::WAIT_CORE) begin
         note_failure("the mmio unit does not start in its wait state");
      end
      if (!ok) begin
         note_failure("cannot open the stimulus file");
      end else begin
         for (int k = 0; k < n_ops; k++) begin
            run_op(k);
         end
         while (exp_q.size() != 0) begin
            @(negedge clk);
         end
      end
      end_run();
   end

endmodule

`default_nettype wire

// ==== verification/task_core_stimulus.txt ====
# op and hex operands: dequeue ts hint ttype arg0 arg1 slot | read addr exp | write addr data
# enqueue ts child_id | finish slot num_children | credit 0 holds and 1 releases
dequeue 00000100 deadbeef 5 11112222 33334444 0a
read c0000004 deadbeef
read c0000008 00000005
read c000000c 11112222
read c0000010 33334444
read c0000014 0000000b
write c0000004 00000aa1
write c0000008 00000003
write c000000c 0000a000
write c0000010 0000b000
enqueue 00000110 0
write c000000c 0000a001
enqueue 00000120 1
write c0000008 0000001f
enqueue 00000130 2
finish 0a 3
dequeue 00000200 cafef00d 7 55556666 77778888 21
read c0000004 cafef00d
read c0000008 00000007
read c0000014 0000000b
credit 0
write c0000004 00000bb2
enqueue 00000210 0
enqueue 00000220 1
write c0000010 0000b001
enqueue 00000230 2
enqueue 00000240 3
credit 1
finish 21 4
dequeue 00000300 00000000 1 00000000 00000000 3f
read c000000c 00000000
enqueue 00000310 0
finish 3f 1

// ==== all.f ====
+incdir+source
source/task_pkg.sv
source/core_bus_pkg.sv
source/task_mmio_unit.sv
source/enq_task_fifo.sv
source/enq_task_port.sv
source/task_core_shell.sv
verification/task_core_shell_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module task_core_shell_tb -f all.f

sim_out=$(./obj_dir/Vtask_core_shell_tb)
echo "$sim_out"

if grep -q "ALL TESTS PASSED" <<< "$sim_out"; then
   exit 0
fi
exit 1
